//--- dma_pkg.sv
// dma register block package with widths, register map, types and mode layout
package dma_pkg;

  parameter int BYTE_W = 8;
  parameter int WORD_W = 16;         // two bytes through the byte pointer
  parameter int AXI_ADDR_W = 6;
  parameter int AXI_DATA_W = 32;
  parameter int MAX_CHANNELS = 4;

  typedef logic [BYTE_W-1:0]     byte_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [1:0]            chan_sel_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

  // channel c holds address at c*8 and word count at c*8+4
  parameter int CHAN_STRIDE = 8;
  parameter int COUNT_OFFSET = 4;
  parameter axi_addr_t CHAN_REGION_END = axi_addr_t'(MAX_CHANNELS * CHAN_STRIDE);

  parameter axi_addr_t REG_STATUS       = 6'h20; // read only
  parameter axi_addr_t REG_REQUEST      = 6'h24;
  parameter axi_addr_t REG_SINGLE_MASK  = 6'h28;
  parameter axi_addr_t REG_MODE         = 6'h2C;
  parameter axi_addr_t REG_CLEAR_PTR    = 6'h30;
  parameter axi_addr_t REG_MASTER_CLEAR = 6'h34;
  parameter axi_addr_t REG_ALL_MASK     = 6'h3C;

  // command byte layout, channel select always in bits 1:0
  parameter int MODE_AUTO_INIT_BIT = 4;
  parameter int REQ_SET_BIT = 2;     // request and single mask

  parameter logic [1:0] AXI_RESP_OKAY = 2'b00;

  function automatic logic is_chan_reg(axi_addr_t a);
    return (a < CHAN_REGION_END) && (a[1:0] == 2'b00);
  endfunction

  function automatic chan_sel_t chan_of(axi_addr_t a);
    return chan_sel_t'(a / CHAN_STRIDE);
  endfunction

  function automatic logic is_count_reg(axi_addr_t a);
    return (a % CHAN_STRIDE) == COUNT_OFFSET;
  endfunction

endpackage

//--- dma_cmd_if.sv
// decoded host commands from the axi port to the channels and the read mux
`timescale 1ns/1ps

interface dma_cmd_if import dma_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) ();

  logic [NUM_CHANNELS-1:0] wr_addr;   // per channel address byte write
  logic [NUM_CHANNELS-1:0] wr_count;  // per channel count byte write
  logic                    byte_hi;   // byte pointer state
  byte_t                   wbyte;
  logic                    mode_wr;
  logic                    req_wr;
  logic                    mask_wr;
  logic                    all_mask_wr;
  chan_sel_t               sel;
  logic                    set_bit;   // auto-init on mode writes
  logic                    master_clear;
  logic                    rd_en;
  axi_addr_t               rd_addr;
  logic                    status_rd;

  modport host (
    output wr_addr, wr_count, byte_hi, wbyte, mode_wr, req_wr, mask_wr,
    output all_mask_wr, sel, set_bit, master_clear, rd_en, rd_addr, status_rd
  );

  modport chan (
    input wr_addr, wr_count, byte_hi, wbyte, mode_wr, req_wr, mask_wr,
    input all_mask_wr, sel, set_bit, master_clear, status_rd
  );

  modport rdbk (
    input rd_en, rd_addr, byte_hi
  );

endinterface

//--- dma_view_if.sv
// per channel register state seen by the read mux
`timescale 1ns/1ps

interface dma_view_if import dma_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) ();

  word_t curr_addr  [NUM_CHANNELS];
  word_t curr_count [NUM_CHANNELS];
  logic  mask       [NUM_CHANNELS];
  logic  request    [NUM_CHANNELS];
  logic  tc         [NUM_CHANNELS];  // terminal count

  // each channel drives only its own element
  modport chan (
    output curr_addr, curr_count, mask, request, tc
  );

  modport rdbk (
    input curr_addr, curr_count, mask, request, tc
  );

endinterface

//--- dma_host_port.sv
// axi4-lite slave for the dma registers with address decode and byte pointer
`timescale 1ns/1ps

module dma_host_port import dma_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  dma_cmd_if.host               cmd
);

  logic                    wr_fire;
  logic                    rd_fire;
  logic                    wr_chan;
  logic                    rd_chan;
  logic                    clear_ptr;
  logic                    byte_ptr;
  logic [NUM_CHANNELS-1:0] addr_stb;
  logic [NUM_CHANNELS-1:0] count_stb;
  byte_t                   wbyte;

  assign wbyte = wdata[BYTE_W-1:0]; // only the low byte carries data

  // address and data are taken together in one cycle
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;

  // a write wins a tie so the byte pointer sees one access per edge
  assign rd_fire = arvalid && !rvalid && !wr_fire;
  assign arready = rd_fire;

  assign bresp = AXI_RESP_OKAY;
  assign rresp = AXI_RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;   // rdata captured in the read mux at the same edge
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // any access to the channel window flips the pointer
  assign wr_chan   = wr_fire && is_chan_reg(awaddr);
  assign rd_chan   = rd_fire && is_chan_reg(araddr);
  assign clear_ptr = wr_fire && (awaddr == REG_CLEAR_PTR);

  always_ff @(posedge clk) begin
    if (rst || cmd.master_clear || clear_ptr) begin
      byte_ptr <= 1'b0;
    end else if (wr_chan || rd_chan) begin
      byte_ptr <= ~byte_ptr;
    end
  end

  always_comb begin
    addr_stb  = '0;
    count_stb = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (wr_chan && chan_of(awaddr) == chan_sel_t'(c)) begin
        addr_stb[c]  = !is_count_reg(awaddr);
        count_stb[c] = is_count_reg(awaddr);
      end
    end
  end

  assign cmd.wr_addr  = addr_stb;
  assign cmd.wr_count = count_stb;
  assign cmd.byte_hi  = byte_ptr;
  assign cmd.wbyte    = wbyte;
  assign cmd.sel      = wbyte[1:0];

  assign cmd.mode_wr      = wr_fire && (awaddr == REG_MODE);
  assign cmd.req_wr       = wr_fire && (awaddr == REG_REQUEST);
  assign cmd.mask_wr      = wr_fire && (awaddr == REG_SINGLE_MASK);
  assign cmd.all_mask_wr  = wr_fire && (awaddr == REG_ALL_MASK);
  assign cmd.master_clear = wr_fire && (awaddr == REG_MASTER_CLEAR);

  // mode carries the auto-init flag where request and mask carry set/clear
  assign cmd.set_bit = cmd.mode_wr ? wbyte[MODE_AUTO_INIT_BIT] : wbyte[REQ_SET_BIT];

  assign cmd.rd_en     = rd_fire;
  assign cmd.rd_addr   = araddr;
  assign cmd.status_rd = rd_fire && (araddr == REG_STATUS); // tc clears after capture

endmodule

//--- dma_word_pair.sv
// base and current 16-bit register pair, loaded a byte at a time
`timescale 1ns/1ps

module dma_word_pair import dma_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  clear,
  input  logic  wr,
  input  logic  byte_hi,
  input  byte_t wbyte,
  input  logic  auto_init,
  input  logic  reload,
  output word_t curr
);

  word_t base;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      base <= '0;
      curr <= '0;
    end else begin
      if (wr) begin
        if (byte_hi) begin
          base[WORD_W-1:BYTE_W] <= wbyte;
        end else begin
          base[BYTE_W-1:0] <= wbyte;
        end
        // with auto-init the current value waits for the next reload
        if (!auto_init) begin
          if (byte_hi) begin
            curr[WORD_W-1:BYTE_W] <= wbyte;
          end else begin
            curr[BYTE_W-1:0] <= wbyte;
          end
        end
      end
      if (reload) begin
        curr <= base;   // old base if a byte lands at the same edge
      end
    end
  end

endmodule

//--- dma_channel.sv
// one dma channel with mode, mask, request, terminal count and its word pairs
`timescale 1ns/1ps

module dma_channel import dma_pkg::*; #(
  parameter int CH = 0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     eop_n,
  dma_cmd_if.chan  cmd,
  dma_view_if.chan view
);

  logic  hit;
  logic  eop;
  logic  auto_init;
  logic  mask;
  logic  request;
  logic  tc;
  word_t curr_addr;
  word_t curr_count;

  assign hit = (cmd.sel == chan_sel_t'(CH));
  assign eop = !eop_n;

  always_ff @(posedge clk) begin
    if (rst || cmd.master_clear) begin
      auto_init <= 1'b0;
      mask      <= 1'b0;
      request   <= 1'b0;
      tc        <= 1'b0;
    end else begin
      if (cmd.mode_wr && hit) auto_init <= cmd.set_bit;
      if (cmd.req_wr && hit) request <= cmd.set_bit;
      if (cmd.mask_wr && hit) mask <= cmd.set_bit;
      if (cmd.all_mask_wr) mask <= cmd.wbyte[CH];
      if (cmd.status_rd) tc <= 1'b0;
      // end of process wins over a command at the same edge
      if (eop) begin
        tc      <= 1'b1;
        request <= 1'b0;
        if (!auto_init) mask <= 1'b1;
      end
    end
  end

  dma_word_pair addr_pair_i (
    .clk       (clk),
    .rst       (rst),
    .clear     (cmd.master_clear),
    .wr        (cmd.wr_addr[CH]),
    .byte_hi   (cmd.byte_hi),
    .wbyte     (cmd.wbyte),
    .auto_init (auto_init),
    .reload    (eop && auto_init),
    .curr      (curr_addr)
  );

  dma_word_pair count_pair_i (
    .clk       (clk),
    .rst       (rst),
    .clear     (cmd.master_clear),
    .wr        (cmd.wr_count[CH]),
    .byte_hi   (cmd.byte_hi),
    .wbyte     (cmd.wbyte),
    .auto_init (auto_init),
    .reload    (eop && auto_init),
    .curr      (curr_count)
  );

  assign view.curr_addr[CH]  = curr_addr;
  assign view.curr_count[CH] = curr_count;
  assign view.mask[CH]       = mask;
  assign view.request[CH]    = request;
  assign view.tc[CH]         = tc;

endmodule

//--- dma_readback.sv
// read data mux for the dma registers with status assembly and registered rdata
`timescale 1ns/1ps

module dma_readback import dma_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  dma_cmd_if.rdbk               cmd,
  dma_view_if.rdbk              view,
  output logic [AXI_DATA_W-1:0] rdata
);

  logic [MAX_CHANNELS-1:0] tc_bits;
  logic [MAX_CHANNELS-1:0] req_bits;
  logic [MAX_CHANNELS-1:0] mask_bits;
  word_t                   sel_word;
  byte_t                   rd_byte;

  // missing channels stay zero in the packed views
  always_comb begin
    tc_bits   = '0;
    req_bits  = '0;
    mask_bits = '0;
    sel_word  = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      tc_bits[c]   = view.tc[c];
      req_bits[c]  = view.request[c];
      mask_bits[c] = view.mask[c];
      if (chan_of(cmd.rd_addr) == chan_sel_t'(c)) begin
        sel_word = is_count_reg(cmd.rd_addr) ? view.curr_count[c] : view.curr_addr[c];
      end
    end
  end

  always_comb begin
    rd_byte = '0;   // unmapped addresses
    if (is_chan_reg(cmd.rd_addr)) begin
      rd_byte = cmd.byte_hi ? sel_word[WORD_W-1:BYTE_W] : sel_word[BYTE_W-1:0];
    end else if (cmd.rd_addr == REG_STATUS) begin
      rd_byte = {req_bits, tc_bits};
    end else if (cmd.rd_addr == REG_ALL_MASK) begin
      rd_byte = byte_t'(mask_bits);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (cmd.rd_en) begin
      rdata <= AXI_DATA_W'(rd_byte); // held until the next accepted read
    end
  end

endmodule

//--- dma_regs_top.sv
// dma register block top with axi4-lite host port and per channel registers
`timescale 1ns/1ps

module dma_regs_top import dma_pkg::*; #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [AXI_ADDR_W-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [AXI_DATA_W-1:0]   wdata,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [AXI_ADDR_W-1:0]   araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [AXI_DATA_W-1:0]   rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  input  logic [NUM_CHANNELS-1:0] eop_n,
  output logic [NUM_CHANNELS-1:0] svc_req
);

  dma_cmd_if  #(.NUM_CHANNELS(NUM_CHANNELS)) cmd ();
  dma_view_if #(.NUM_CHANNELS(NUM_CHANNELS)) view ();

  dma_host_port #(.NUM_CHANNELS(NUM_CHANNELS)) host_i (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cmd     (cmd.host)
  );

  dma_readback #(.NUM_CHANNELS(NUM_CHANNELS)) rdbk_i (
    .clk   (clk),
    .rst   (rst),
    .cmd   (cmd.rdbk),
    .view  (view.rdbk),
    .rdata (rdata)
  );

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    dma_channel #(.CH(c)) chan_i (
      .clk   (clk),
      .rst   (rst),
      .eop_n (eop_n[c]),
      .cmd   (cmd.chan),
      .view  (view.chan)
    );

    assign svc_req[c] = view.request[c] && !view.mask[c]; // pending and not masked
  end

endmodule

//--- dma_host_port_asserts.sv
// axi4-lite handshake checks for the dma host port
`timescale 1ns/1ps

module dma_host_port_asserts (
  input logic clk,
  input logic rst,
  input logic awready,
  input logic wready,
  input logic bvalid,
  input logic bready,
  input logic arready,
  input logic rvalid,
  input logic rready
);

  // address and data always taken in the same cycle
  a_aw_w_together: assert property (@(posedge clk) awready == wready)
    else $error("awready and wready differ");

  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  // one outstanding transfer per side
  a_one_write: assert property (@(posedge clk) disable iff (rst) bvalid |-> !awready)
    else $error("write accepted while a response is pending");

  a_one_read: assert property (@(posedge clk) disable iff (rst) rvalid |-> !arready)
    else $error("read accepted while read data is pending");

  a_idle_in_reset: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
    else $error("valid output high during reset");

endmodule

bind dma_host_port dma_host_port_asserts host_port_asserts_i (
  .clk     (clk),
  .rst     (rst),
  .awready (awready),
  .wready  (wready),
  .bvalid  (bvalid),
  .bready  (bready),
  .arready (arready),
  .rvalid  (rvalid),
  .rready  (rready)
);

//--- tb_dma_regs.sv
// testbench for the dma register block with a reference model and read compare
`timescale 1ns/1ps

module tb_dma_regs import dma_pkg::*; ();

  localparam int NUM_CH = 4;
  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_OPS = 200;      // upper bound on bus operations and eop pulses
  localparam int OP_CYCLES = 10;     // an operation takes up to six cycles with back-pressure

  logic                  clk;
  logic                  rst;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic [NUM_CH-1:0]     eop_n;
  logic [NUM_CH-1:0]     svc_req;

  // model state where the second index is 0 for address and 1 for count
  word_t       m_base [NUM_CH][2];
  word_t       m_curr [NUM_CH][2];
  logic [3:0]  m_auto;
  logic [3:0]  m_mask;
  logic [3:0]  m_req;
  logic [3:0]  m_tc;
  logic        m_ptr;
  logic [31:0] seed;
  byte_t       exp_q [$];   // expected read bytes in issue order

  dma_regs_top #(.NUM_CHANNELS(NUM_CH)) dut_i (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .eop_n   (eop_n),
    .svc_req (svc_req)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic axi_addr_t reg_addr(input int ch, input int k);
    return axi_addr_t'(ch * 8 + k * 4);
  endfunction

  function automatic logic in_chan_window(input axi_addr_t addr);
    return (addr < 6'h20) && (addr[1:0] == 2'b00);
  endfunction

  // expected byte for a read issued in the present model state
  function automatic byte_t ref_read(input axi_addr_t addr);
    word_t w;
    if (in_chan_window(addr)) begin
      w = m_curr[addr[4:3]][addr[2]];
      return m_ptr ? w[15:8] : w[7:0];
    end
    if (addr == REG_STATUS) return {m_req, m_tc};
    if (addr == REG_ALL_MASK) return {4'h0, m_mask};
    return 8'h00;
  endfunction

  task automatic model_clear();
    for (int c = 0; c < NUM_CH; c++) begin
      for (int k = 0; k < 2; k++) begin
        m_base[c][k] = '0;
        m_curr[c][k] = '0;
      end
    end
    m_auto = '0;
    m_mask = '0;
    m_req  = '0;
    m_tc   = '0;
    m_ptr  = 1'b0;
  endtask

  task automatic model_write(input axi_addr_t addr, input byte_t data);
    int ch;
    int k;
    if (in_chan_window(addr)) begin
      ch = int'(addr[4:3]);
      k  = int'(addr[2]);
      m_base[ch][k][{m_ptr, 3'b000} +: 8] = data;
      if (!m_auto[ch]) m_curr[ch][k][{m_ptr, 3'b000} +: 8] = data; // base only with auto-init
      m_ptr = !m_ptr;
    end
    case (addr)
      REG_REQUEST:      m_req[data[1:0]] = data[2];
      REG_SINGLE_MASK:  m_mask[data[1:0]] = data[2];
      REG_MODE:         m_auto[data[1:0]] = data[4];
      REG_ALL_MASK:     m_mask = data[3:0];
      REG_CLEAR_PTR:    m_ptr = 1'b0;
      REG_MASTER_CLEAR: model_clear();
      default: ;
    endcase
  endtask

  task automatic model_eop(input int ch);
    m_tc[ch]  = 1'b1;
    m_req[ch] = 1'b0;
    if (m_auto[ch]) begin
      m_curr[ch][0] = m_base[ch][0];
      m_curr[ch][1] = m_base[ch][1];
    end else begin
      m_mask[ch] = 1'b1;
    end
  endtask

  task automatic check_svc();
    check_value("svc_req", 32'(svc_req), 32'(m_req & ~m_mask));
  endtask

  task automatic axi_write(input axi_addr_t addr, input byte_t data);
    int hold;
    hold = int'(next_rand() % 32'd4);
    @(negedge clk);
    awaddr  = addr;
    wdata   = 32'(data);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);   // taken at the rising edge in between
    awvalid = 1'b0;
    wvalid  = 1'b0;
    model_write(addr, data);
    repeat (hold) @(negedge clk);   // response held back
    bready = 1'b1;
    #1;
    check_value("bvalid", 32'(bvalid), 32'd1);
    check_value("bresp", 32'(bresp), 32'(AXI_RESP_OKAY));
    while (bvalid) begin
      @(negedge clk);
      #1;
    end
    check_svc();
  endtask

  task automatic axi_read(input axi_addr_t addr);
    int hold;
    hold = int'(next_rand() % 32'd4);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    exp_q.push_back(ref_read(addr));
    @(negedge clk);
    arvalid = 1'b0;
    model_read(addr);
    repeat (hold) @(negedge clk);   // read data held back
    rready = 1'b1;
    #1;
    while (rvalid) begin
      @(negedge clk);
      #1;
    end
    check_svc();
  endtask

  task automatic model_read(input axi_addr_t addr);
    if (in_chan_window(addr)) m_ptr = !m_ptr;
    if (addr == REG_STATUS) m_tc = '0;
  endtask

  task automatic pulse_eop(input int ch);
    @(negedge clk);
    eop_n[ch] = 1'b0;   // low across exactly one rising edge
    @(negedge clk);
    eop_n[ch] = 1'b1;
    model_eop(ch);
    #1;
    check_svc();
  endtask

  task automatic write_word(input axi_addr_t addr, input word_t w);
    axi_write(addr, w[7:0]);
    axi_write(addr, w[15:8]);
  endtask

  task automatic read_word(input axi_addr_t addr);
    axi_read(addr);
    axi_read(addr);
  endtask

  task automatic read_all_regs();
    for (int c = 0; c < NUM_CH; c++) begin
      read_word(reg_addr(c, 0));
      read_word(reg_addr(c, 1));
    end
    axi_read(REG_STATUS);
    axi_read(REG_ALL_MASK);
  endtask

  // read data checked every cycle rvalid is high and retired at the handshake
  always @(negedge clk) begin
    #1;
    if (rvalid) begin
      if (exp_q.size() == 0) begin
        fail_run("read data returned with no read outstanding");
      end else begin
        check_value("rdata", rdata, 32'(exp_q[0]));
        check_value("rresp", 32'(rresp), 32'(AXI_RESP_OKAY));
        if (rready) void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + NUM_OPS * OP_CYCLES) @(posedge clk);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin
    word_t       w;
    logic [31:0] r;
    seed    = 32'h131c_7adc;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    eop_n   = '1;
    model_clear();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    #1;
    check_svc();

    read_all_regs();   // everything zero out of reset

    // byte-wide loads of every address and count
    for (int c = 0; c < NUM_CH; c++) begin
      for (int k = 0; k < 2; k++) begin
        w = word_t'(next_rand());
        write_word(reg_addr(c, k), w);
      end
    end
    for (int c = 0; c < NUM_CH; c++) begin
      read_word(reg_addr(c, 0));
      read_word(reg_addr(c, 1));
    end
    w = word_t'(next_rand());
    axi_write(reg_addr(1, 0), w[15:8]);   // lands in the low byte
    axi_write(REG_CLEAR_PTR, 8'h00);
    write_word(reg_addr(1, 0), w);
    read_word(reg_addr(1, 0));
    axi_read(reg_addr(2, 1));
    axi_write(REG_CLEAR_PTR, 8'h00);
    read_word(reg_addr(2, 1));

    // request and mask mix
    repeat (24) begin
      r = next_rand();
      case (r[9:8])
        2'd0:    axi_write(REG_REQUEST, {5'b0, r[2], r[1:0]});
        2'd1:    axi_write(REG_SINGLE_MASK, {5'b0, r[2], r[1:0]});
        2'd2:    axi_write(REG_ALL_MASK, {4'h0, r[7:4]});
        default: axi_write(REG_REQUEST, {5'b0, 1'b1, r[1:0]});
      endcase
      axi_read(REG_STATUS);
    end
    axi_read(REG_ALL_MASK);

    // eop on channel 1 without auto-init
    axi_write(REG_ALL_MASK, 8'h00);
    axi_write(REG_REQUEST, 8'h05);
    pulse_eop(1);
    axi_read(REG_STATUS);
    axi_read(REG_STATUS);   // tc now cleared
    axi_read(REG_ALL_MASK);
    read_word(reg_addr(1, 0));
    read_word(reg_addr(1, 1));

    // auto-init on channel 2
    axi_write(REG_MODE, 8'h12);
    write_word(reg_addr(2, 0), word_t'(next_rand()));
    write_word(reg_addr(2, 1), word_t'(next_rand()));
    read_word(reg_addr(2, 0));
    read_word(reg_addr(2, 1));
    axi_write(REG_REQUEST, 8'h06);
    pulse_eop(2);
    read_word(reg_addr(2, 0));
    read_word(reg_addr(2, 1));
    axi_read(REG_STATUS);
    axi_read(REG_ALL_MASK);

    // master clear with tc, request, mask, auto-init and the pointer all set
    pulse_eop(0);
    axi_write(REG_REQUEST, 8'h04);
    axi_write(reg_addr(3, 0), 8'h5a);
    axi_write(REG_MASTER_CLEAR, 8'h00);
    read_all_regs();
    axi_write(reg_addr(2, 0), 8'hc3);   // low byte and current value once fully cleared
    axi_write(REG_CLEAR_PTR, 8'h00);
    read_word(reg_addr(2, 0));

    repeat (2) @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run("reads were issued that never returned data");
    end
  end

endmodule

//--- sources.f
dma_pkg.sv
dma_cmd_if.sv
dma_view_if.sv
dma_host_port.sv
dma_word_pair.sv
dma_channel.sv
dma_readback.sv
dma_regs_top.sv
dma_host_port_asserts.sv
tb_dma_regs.sv

//--- Makefile
# verilator build and run of the dma register block testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_regs
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "TESTBENCH FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -qx "TESTBENCH PASSED" $(LOG) || { echo "test ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
